// ==== verilog/n64_ppu_pkg.sv ====
// N64 post-processing definitions

package n64_ppu_pkg;

  // ==================================================
  // Widths
  // ==================================================

  // Channel width on the N64 video bus
  localparam int COLOR_W_IN  = 7;
  // Channel width after expansion
  localparam int COLOR_W_OUT = 8;
  // Line counters in vinfo detection and OSD
  localparam int LINE_CNT_W  = 10;

  // ==================================================
  // Pixel and sync types
  // ==================================================

  typedef logic [COLOR_W_IN-1:0]  color_in_t;
  typedef logic [COLOR_W_OUT-1:0] color_out_t;

  // Red in the upper byte, blue in the lower byte
  typedef struct packed {
    color_out_t r;
    color_out_t g;
    color_out_t b;
  } rgb_t;

  // All flags active high
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
  } sync_t;

  // ==================================================
  // Constants
  // ==================================================

  // Colour of a set OSD bitmap pixel
  localparam rgb_t OSD_FG_COLOR = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};

  // Bus words of one pixel, sync word marked by nVDSYNC low
  typedef enum logic [1:0] {
    PHASE_SYNC = 2'd0,
    PHASE_R    = 2'd1,
    PHASE_G    = 2'd2,
    PHASE_B    = 2'd3
  } phase_t;

endpackage

// ==== verilog/video_stream_if.sv ====
// Pixel stream between pipeline stages
`timescale 1ns/100ps

interface video_stream_if;

  // One-cycle strobe per pixel, no back-pressure
  logic                valid;
  // Held with the pixel while valid is low
  n64_ppu_pkg::sync_t  sync;
  n64_ppu_pkg::rgb_t   pixel;

  modport src (
    output valid,
    output sync,
    output pixel
  );

  modport dst (
    input valid,
    input sync,
    input pixel
  );

endinterface

// ==== verilog/n64_vdemux.sv ====
// N64 video bus demultiplexer
`timescale 1ns/100ps

module n64_vdemux (
  input  logic                   N64_CLK_i,
  input  logic                   rst_n_i,
  input  logic                   nVDSYNC_i,
  input  n64_ppu_pkg::color_in_t VD_i,
  input  logic                   n16bit_i,
  video_stream_if.src            out,
  output logic                   vsync_word_o,
  output logic                   hsync_word_o
);

  n64_ppu_pkg::phase_t    phase;
  n64_ppu_pkg::sync_t     sync_q;
  n64_ppu_pkg::color_in_t r_q;
  n64_ppu_pkg::color_in_t g_q;

  // Optional 16-bit masking, then replicate the MSB into the new LSB
  function automatic n64_ppu_pkg::color_out_t expand(input n64_ppu_pkg::color_in_t c,
                                                     input logic n16bit);
    n64_ppu_pkg::color_in_t m;
    m = c;
    if (n16bit)
      m[1:0] = 2'b00;
    return {m, m[n64_ppu_pkg::COLOR_W_IN-1]};
  endfunction

  // Phase tracking and pixel output
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase     <= n64_ppu_pkg::PHASE_SYNC;
      sync_q    <= '0;
      out.valid <= 1'b0;
      out.sync  <= '0;
      out.pixel <= '0;
    end else begin
      out.valid <= 1'b0;
      if (!nVDSYNC_i) begin
        sync_q.vsync <= ~VD_i[3];
        sync_q.hsync <= ~VD_i[1];
        sync_q.de    <= VD_i[3] & VD_i[1];
        phase        <= n64_ppu_pkg::PHASE_R;
      end else begin
        case (phase)
          n64_ppu_pkg::PHASE_R: phase <= n64_ppu_pkg::PHASE_G;
          n64_ppu_pkg::PHASE_G: phase <= n64_ppu_pkg::PHASE_B;
          n64_ppu_pkg::PHASE_B: begin
            out.valid   <= 1'b1;
            out.sync    <= sync_q;
            out.pixel.r <= expand(r_q, n16bit_i);
            out.pixel.g <= expand(g_q, n16bit_i);
            out.pixel.b <= expand(VD_i, n16bit_i);
            phase       <= n64_ppu_pkg::PHASE_SYNC;
          end
          // Idle until the next sync word
          default: phase <= n64_ppu_pkg::PHASE_SYNC;
        endcase
      end
    end
  end

  // Colour words held until B arrives
  always_ff @(posedge N64_CLK_i) begin
    if (nVDSYNC_i && phase == n64_ppu_pkg::PHASE_R)
      r_q <= VD_i;
    if (nVDSYNC_i && phase == n64_ppu_pkg::PHASE_G)
      g_q <= VD_i;
  end

  assign vsync_word_o = sync_q.vsync;
  assign hsync_word_o = sync_q.hsync;

endmodule

// ==== verilog/n64_vinfo_detect.sv ====
// PAL and 480i detection
`timescale 1ns/100ps

module n64_vinfo_detect #(
  parameter int PAL_LINE_THRESHOLD = 288
) (
  input  logic N64_CLK_i,
  input  logic rst_n_i,
  input  logic vsync_i,
  input  logic hsync_i,
  output logic palmode_o,
  output logic n64_480i_o
);

  logic                               vsync_q;
  logic                               hsync_q;
  logic                               vsync_rise;
  logic                               hsync_rise;
  logic [n64_ppu_pkg::LINE_CNT_W-1:0] line_cnt;
  logic [n64_ppu_pkg::LINE_CNT_W-1:0] prev_cnt;

  assign vsync_rise = vsync_i & ~vsync_q;
  assign hsync_rise = hsync_i & ~hsync_q;

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vsync_q    <= 1'b0;
      hsync_q    <= 1'b0;
      line_cnt   <= '0;
      prev_cnt   <= '0;
      palmode_o  <= 1'b0;
      n64_480i_o <= 1'b0;
    end else begin
      vsync_q <= vsync_i;
      hsync_q <= hsync_i;
      if (vsync_rise) begin
        // Evaluate the line count of the field just ended
        palmode_o  <= (line_cnt > PAL_LINE_THRESHOLD);
        n64_480i_o <= (line_cnt != prev_cnt);
        prev_cnt   <= line_cnt;
        // A line starting together with vsync belongs to the new field
        line_cnt   <= {{(n64_ppu_pkg::LINE_CNT_W-1){1'b0}}, hsync_rise};
      end else if (hsync_rise) begin
        line_cnt <= line_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/scanline_emu.sv ====
// Scanline emulation
`timescale 1ns/100ps

module scanline_emu (
  input  logic        N64_CLK_i,
  input  logic        rst_n_i,
  video_stream_if.dst in,
  video_stream_if.src out,
  input  logic        sl_en_i,
  input  logic [7:0]  sl_strength_i
);

  logic              odd_q;
  logic              odd_nxt;
  logic              hsync_q;
  logic [8:0]        gain;
  n64_ppu_pkg::rgb_t dimmed;

  // Scale one channel by gain/256
  function automatic n64_ppu_pkg::color_out_t dim(input n64_ppu_pkg::color_out_t c,
                                                  input logic [8:0] g);
    logic [16:0] prod;
    prod = c * g;
    return prod[15:8];
  endfunction

  // Line parity including the current pixel
  always_comb begin
    odd_nxt = odd_q;
    if (in.sync.vsync)
      odd_nxt = 1'b0;
    else if (in.sync.hsync && !hsync_q)
      odd_nxt = ~odd_q;
  end

  assign gain     = 9'd256 - {1'b0, sl_strength_i};
  assign dimmed.r = dim(in.pixel.r, gain);
  assign dimmed.g = dim(in.pixel.g, gain);
  assign dimmed.b = dim(in.pixel.b, gain);

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      odd_q     <= 1'b0;
      hsync_q   <= 1'b0;
      out.valid <= 1'b0;
      out.sync  <= '0;
      out.pixel <= '0;
    end else begin
      out.valid <= in.valid;
      if (in.valid) begin
        hsync_q   <= in.sync.hsync;
        odd_q     <= odd_nxt;
        out.sync  <= in.sync;
        out.pixel <= (sl_en_i && odd_nxt) ? dimmed : in.pixel;
      end
    end
  end

endmodule

// ==== verilog/osd_overlay.sv ====
// OSD bitmap overlay
`timescale 1ns/100ps

module osd_overlay #(
  parameter  int OSD_W  = 16,
  parameter  int OSD_H  = 16,
  localparam int OSD_AW = $clog2(OSD_W * OSD_H)
) (
  input  logic                               N64_CLK_i,
  input  logic                               rst_n_i,
  video_stream_if.dst                        in,
  input  logic                               osd_en_i,
  input  logic [9:0]                         hoffset_i,
  input  logic [n64_ppu_pkg::LINE_CNT_W-1:0] voffset_i,
  input  logic                               wr_i,
  input  logic [OSD_AW-1:0]                  waddr_i,
  input  logic                               wdata_i,
  output logic                               valid_o,
  output n64_ppu_pkg::sync_t                 sync_o,
  output n64_ppu_pkg::rgb_t                  pixel_o
);

  // ==================================================
  // Bitmap memory
  // ==================================================

  logic osd_mem [OSD_W*OSD_H];

  always_ff @(posedge N64_CLK_i) begin
    if (wr_i)
      osd_mem[waddr_i] <= wdata_i;
  end

  // ==================================================
  // Position tracking and window
  // ==================================================

  logic [9:0]                         hpos;
  logic [n64_ppu_pkg::LINE_CNT_W-1:0] vpos;
  logic                               hsync_q;
  logic [9:0]                         col;
  logic [n64_ppu_pkg::LINE_CNT_W-1:0] row;
  logic                               in_win;
  logic [OSD_AW-1:0]                  rd_addr;
  logic                               osd_hit;

  // Positions relative to the window origin
  assign col    = hpos - hoffset_i;
  assign row    = vpos - voffset_i;
  assign in_win = (hpos >= hoffset_i) && (col < OSD_W) &&
                  (vpos >= voffset_i) && (row < OSD_H);

  assign rd_addr = OSD_AW'(row * OSD_W + col);
  assign osd_hit = osd_en_i & in.sync.de & in_win & osd_mem[rd_addr];

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hpos    <= '0;
      vpos    <= '0;
      hsync_q <= 1'b0;
      valid_o <= 1'b0;
      sync_o  <= '0;
      pixel_o <= '0;
    end else begin
      valid_o <= in.valid;
      if (in.valid) begin
        hsync_q <= in.sync.hsync;
        if (in.sync.vsync)
          vpos <= '0;
        else if (in.sync.hsync && !hsync_q)
          vpos <= vpos + 1'b1;
        // Column counts active pixels only
        if (in.sync.hsync)
          hpos <= '0;
        else if (in.sync.de)
          hpos <= hpos + 1'b1;
        sync_o  <= in.sync;
        pixel_o <= osd_hit ? n64_ppu_pkg::OSD_FG_COLOR : in.pixel;
      end
    end
  end

endmodule

// ==== verilog/n64_ppu_top.sv ====
// N64 post-processing top level
`timescale 1ns/100ps

module n64_ppu_top #(
  parameter  int PAL_LINE_THRESHOLD = 288,
  parameter  int OSD_W              = 16,
  parameter  int OSD_H              = 16,
  localparam int OSD_AW             = $clog2(OSD_W * OSD_H)
) (
  input  logic                               N64_CLK_i,
  input  logic                               rst_n_i,
  input  logic                               nVDSYNC_i,
  input  logic [6:0]                         VD_i,
  input  logic                               cfg_n16bit_i,
  input  logic                               sl_en_i,
  input  logic [7:0]                         sl_strength_i,
  input  logic                               osd_en_i,
  input  logic [9:0]                         osd_hoffset_i,
  input  logic [n64_ppu_pkg::LINE_CNT_W-1:0] osd_voffset_i,
  input  logic                               osd_wr_i,
  input  logic [OSD_AW-1:0]                  osd_waddr_i,
  input  logic                               osd_wdata_i,
  output logic                               palmode_o,
  output logic                               n64_480i_o,
  output logic                               VD_VALID_o,
  output logic                               VSYNC_o,
  output logic                               HSYNC_o,
  output logic                               DE_o,
  output logic [23:0]                        VD_o
);

  video_stream_if demux_s ();
  video_stream_if sl_s ();

  logic               vsync_word;
  logic               hsync_word;
  n64_ppu_pkg::sync_t osd_sync;

  // ==================================================
  // Input side
  // ==================================================

  n64_vdemux vdemux_u (
    .N64_CLK_i   (N64_CLK_i),
    .rst_n_i     (rst_n_i),
    .nVDSYNC_i   (nVDSYNC_i),
    .VD_i        (VD_i),
    .n16bit_i    (cfg_n16bit_i),
    .out         (demux_s.src),
    .vsync_word_o(vsync_word),
    .hsync_word_o(hsync_word)
  );

  n64_vinfo_detect #(
    .PAL_LINE_THRESHOLD(PAL_LINE_THRESHOLD)
  ) vinfo_u (
    .N64_CLK_i (N64_CLK_i),
    .rst_n_i   (rst_n_i),
    .vsync_i   (vsync_word),
    .hsync_i   (hsync_word),
    .palmode_o (palmode_o),
    .n64_480i_o(n64_480i_o)
  );

  // ==================================================
  // Post-processing
  // ==================================================

  scanline_emu scanline_u (
    .N64_CLK_i    (N64_CLK_i),
    .rst_n_i      (rst_n_i),
    .in           (demux_s.dst),
    .out          (sl_s.src),
    .sl_en_i      (sl_en_i),
    .sl_strength_i(sl_strength_i)
  );

  osd_overlay #(
    .OSD_W(OSD_W),
    .OSD_H(OSD_H)
  ) osd_u (
    .N64_CLK_i(N64_CLK_i),
    .rst_n_i  (rst_n_i),
    .in       (sl_s.dst),
    .osd_en_i (osd_en_i),
    .hoffset_i(osd_hoffset_i),
    .voffset_i(osd_voffset_i),
    .wr_i     (osd_wr_i),
    .waddr_i  (osd_waddr_i),
    .wdata_i  (osd_wdata_i),
    .valid_o  (VD_VALID_o),
    .sync_o   (osd_sync),
    .pixel_o  (VD_o)
  );

  // Final stream onto plain ports
  assign VSYNC_o = osd_sync.vsync;
  assign HSYNC_o = osd_sync.hsync;
  assign DE_o    = osd_sync.de;

endmodule

// ==== testbench/tb_n64_ppu.sv ====
// N64 post-processing testbench
`timescale 1ns/100ps

module tb_n64_ppu;

  localparam int CLK_PERIOD = 40;
  localparam int OSD_W      = 16;
  localparam int OSD_H      = 16;
  localparam int OSD_AW     = $clog2(OSD_W * OSD_H);
  localparam int NUM_ROWS   = 9;

  // One table row with field shape, configuration and expected video info
  typedef struct packed {
    logic [9:0] lines;
    logic       alt;
    logic       n16bit;
    logic       sl_en;
    logic [7:0] strength;
    logic       osd_en;
    logic [9:0] hoff;
    logic [9:0] voff;
    logic       exp_pal;
    logic       exp_480i;
  } row_t;

  logic                               N64_CLK_i = 1'b0;
  logic                               rst_n_i;
  logic                               nVDSYNC_i;
  logic [6:0]                         VD_i;
  logic                               cfg_n16bit_i;
  logic                               sl_en_i;
  logic [7:0]                         sl_strength_i;
  logic                               osd_en_i;
  logic [9:0]                         osd_hoffset_i;
  logic [n64_ppu_pkg::LINE_CNT_W-1:0] osd_voffset_i;
  logic                               osd_wr_i;
  logic [OSD_AW-1:0]                  osd_waddr_i;
  logic                               osd_wdata_i;
  logic                               palmode_o;
  logic                               n64_480i_o;
  logic                               VD_VALID_o;
  logic                               VSYNC_o;
  logic                               HSYNC_o;
  logic                               DE_o;
  logic [23:0]                        VD_o;

  row_t                rows [NUM_ROWS];
  string               test_name [NUM_ROWS];
  row_t                cur_row;
  string               cur_name;
  logic                bitmap [OSD_W*OSD_H];
  n64_ppu_pkg::rgb_t   exp_rgb_q [$];
  n64_ppu_pkg::sync_t  exp_sync_q [$];
  int                  pix_cnt = 0;

  n64_ppu_top #(
    .PAL_LINE_THRESHOLD(288),
    .OSD_W             (OSD_W),
    .OSD_H             (OSD_H)
  ) DUT (.*);

  always #(CLK_PERIOD / 2) N64_CLK_i = ~N64_CLK_i;

  // ==================================================
  // Checks
  // ==================================================

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_rgb(input string name, input n64_ppu_pkg::rgb_t exp,
                           input n64_ppu_pkg::rgb_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected pixel %06h, actual %06h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_sync(input string name, input n64_ppu_pkg::sync_t exp,
                            input n64_ppu_pkg::sync_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected vsync/hsync/de %03b, actual %03b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
      abort_run();
    end
  endtask

  // ==================================================
  // Reference model
  // ==================================================

  // 16-bit mode drops the two low source bits before the MSB fills the new LSB
  function automatic n64_ppu_pkg::color_out_t expand_channel(input n64_ppu_pkg::color_in_t c,
                                                            input logic n16);
    logic [6:0] src;
    src = n16 ? {c[6:2], 2'b00} : c;
    return {src, src[6]};
  endfunction

  function automatic n64_ppu_pkg::color_out_t scale_channel(input n64_ppu_pkg::color_out_t c,
                                                           input logic [7:0] s);
    int prod;
    prod = int'(c) * (256 - int'(s));
    return n64_ppu_pkg::color_out_t'(prod / 256);
  endfunction

  // Sends one pixel as sync, R, G, B words and queues its expected output
  task automatic drive_pixel(input logic vs, input logic hs, input int j, input int k);
    logic [6:0]             sync_word;
    n64_ppu_pkg::color_in_t r;
    n64_ppu_pkg::color_in_t g;
    n64_ppu_pkg::color_in_t b;
    n64_ppu_pkg::rgb_t      px;
    n64_ppu_pkg::sync_t     sy;
    int                     orow;
    int                     ocol;
    sync_word    = 7'($urandom);
    sync_word[3] = ~vs;
    sync_word[1] = ~hs;
    r = 7'($urandom);
    g = 7'($urandom);
    b = 7'($urandom);
    sy = '{vsync: vs, hsync: hs, de: !vs && !hs};
    px.r = expand_channel(r, cur_row.n16bit);
    px.g = expand_channel(g, cur_row.n16bit);
    px.b = expand_channel(b, cur_row.n16bit);
    // Lines after vsync count from 1 and the odd ones are darkened
    if (cur_row.sl_en && !vs && j[0]) begin
      px.r = scale_channel(px.r, cur_row.strength);
      px.g = scale_channel(px.g, cur_row.strength);
      px.b = scale_channel(px.b, cur_row.strength);
    end
    orow = j - int'(cur_row.voff);
    ocol = k - int'(cur_row.hoff);
    if (cur_row.osd_en && sy.de && orow >= 0 && orow < OSD_H && ocol >= 0 && ocol < OSD_W)
      if (bitmap[orow*OSD_W + ocol])
        px = n64_ppu_pkg::OSD_FG_COLOR;
    exp_rgb_q.push_back(px);
    exp_sync_q.push_back(sy);
    @(posedge N64_CLK_i);
    nVDSYNC_i <= 1'b0;
    VD_i      <= sync_word;
    @(posedge N64_CLK_i);
    nVDSYNC_i <= 1'b1;
    VD_i      <= r;
    @(posedge N64_CLK_i);
    VD_i      <= g;
    @(posedge N64_CLK_i);
    VD_i      <= b;
  endtask

  task automatic write_bitmap();
    logic bit_val;
    for (int a = 0; a < OSD_W*OSD_H; a++) begin
      bit_val   = 1'($urandom);
      bitmap[a] = bit_val;
      @(posedge N64_CLK_i);
      osd_wr_i    <= 1'b1;
      osd_waddr_i <= OSD_AW'(a);
      osd_wdata_i <= bit_val;
    end
    @(posedge N64_CLK_i);
    osd_wr_i <= 1'b0;
  endtask

  // Three fields of 8-pixel lines with 3 vsync lines at the start of each
  task automatic apply_row(input int idx);
    int lines;
    cur_row  = rows[idx];
    cur_name = test_name[idx];
    @(posedge N64_CLK_i);
    cfg_n16bit_i  <= cur_row.n16bit;
    sl_en_i       <= cur_row.sl_en;
    sl_strength_i <= cur_row.strength;
    osd_en_i      <= cur_row.osd_en;
    osd_hoffset_i <= cur_row.hoff;
    osd_voffset_i <= cur_row.voff;
    for (int f = 0; f < 3; f++) begin
      lines = int'(cur_row.lines) + ((cur_row.alt && f == 1) ? 1 : 0);
      for (int l = 0; l < lines; l++)
        for (int p = 0; p < 8; p++)
          drive_pixel(l < 3, p < 2, l - 2, p - 2);
    end
    while (exp_rgb_q.size() != 0)
      @(negedge N64_CLK_i);
    // Flags now hold the second field compared with the first
    check_flag({cur_name, " palmode"}, cur_row.exp_pal, palmode_o);
    check_flag({cur_name, " 480i"}, cur_row.exp_480i, n64_480i_o);
  endtask

  // Output pixels are checked in the middle of the cycle
  always @(negedge N64_CLK_i) begin
    if (rst_n_i && VD_VALID_o) begin
      if (exp_rgb_q.size() == 0) begin
        $display("Output pixel strobe arrived while no pixel was expected");
        abort_run();
      end else begin
        check_rgb($sformatf("%s pixel %0d", cur_name, pix_cnt), exp_rgb_q.pop_front(), VD_o);
        check_sync($sformatf("%s pixel %0d", cur_name, pix_cnt), exp_sync_q.pop_front(),
                   {VSYNC_o, HSYNC_o, DE_o});
        pix_cnt++;
      end
    end
  end

  initial begin : watchdog
    longint cycles;
    #1;
    cycles = 5 + OSD_W*OSD_H + 64;
    for (int i = 0; i < NUM_ROWS; i++)
      cycles += (3 * longint'(rows[i].lines) + rows[i].alt) * 32 + 64;
    #(2 * cycles * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in %0d cycles", 2 * cycles);
    abort_run();
  end

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    void'($urandom(32'h8b349014));
    rst_n_i       = 1'b0;
    nVDSYNC_i     = 1'b1;
    VD_i          = '0;
    cfg_n16bit_i  = 1'b0;
    sl_en_i       = 1'b0;
    sl_strength_i = '0;
    osd_en_i      = 1'b0;
    osd_hoffset_i = '0;
    osd_voffset_i = '0;
    osd_wr_i      = 1'b0;
    osd_waddr_i   = '0;
    osd_wdata_i   = 1'b0;

    // lines, alt, n16bit, sl_en, strength, osd_en, hoff, voff, pal, 480i
    test_name[0] = "passthrough";
    rows[0] = '{10'd20, 1'b0, 1'b0, 1'b0, 8'd0, 1'b0, 10'd0, 10'd0, 1'b0, 1'b0};
    test_name[1] = "mode16";
    rows[1] = '{10'd20, 1'b0, 1'b1, 1'b0, 8'd0, 1'b0, 10'd0, 10'd0, 1'b0, 1'b0};
    test_name[2] = "scanline_s64";
    rows[2] = '{10'd20, 1'b0, 1'b0, 1'b1, 8'd64, 1'b0, 10'd0, 10'd0, 1'b0, 1'b0};
    test_name[3] = "scanline_s200";
    rows[3] = '{10'd20, 1'b0, 1'b0, 1'b1, 8'd200, 1'b0, 10'd0, 10'd0, 1'b0, 1'b0};
    test_name[4] = "scanline_s255_mode16";
    rows[4] = '{10'd20, 1'b0, 1'b1, 1'b1, 8'd255, 1'b0, 10'd0, 10'd0, 1'b0, 1'b0};
    test_name[5] = "osd_window";
    rows[5] = '{10'd26, 1'b0, 1'b0, 1'b0, 8'd0, 1'b1, 10'd1, 10'd5, 1'b0, 1'b0};
    test_name[6] = "ntsc_262";
    rows[6] = '{10'd262, 1'b0, 1'b0, 1'b0, 8'd0, 1'b0, 10'd0, 10'd0, 1'b0, 1'b0};
    test_name[7] = "pal_312";
    rows[7] = '{10'd312, 1'b0, 1'b0, 1'b0, 8'd0, 1'b0, 10'd0, 10'd0, 1'b1, 1'b0};
    test_name[8] = "interlaced_262_263";
    rows[8] = '{10'd262, 1'b1, 1'b0, 1'b0, 8'd0, 1'b0, 10'd0, 10'd0, 1'b0, 1'b1};

    repeat (5) @(posedge N64_CLK_i);
    rst_n_i <= 1'b1;
    @(negedge N64_CLK_i);
    check_flag("reset palmode", 1'b0, palmode_o);
    check_flag("reset 480i", 1'b0, n64_480i_o);
    check_flag("reset valid", 1'b0, VD_VALID_o);
    check_sync("reset sync", '0, {VSYNC_o, HSYNC_o, DE_o});
    check_rgb("reset pixel", '0, VD_o);

    write_bitmap();
    for (int i = 0; i < NUM_ROWS; i++)
      apply_row(i);

    // A few idle cycles so that a stray output strobe is still caught
    repeat (8) @(posedge N64_CLK_i);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/n64_ppu_pkg.sv
verilog/video_stream_if.sv
verilog/n64_vdemux.sv
verilog/n64_vinfo_detect.sv
verilog/scanline_emu.sv
verilog/osd_overlay.sv
verilog/n64_ppu_top.sv
testbench/tb_n64_ppu.sv

// ==== Makefile ====
# Verilator build for the N64 post-processing testbench

VERILATOR  ?= verilator
TOP        := tb_n64_ppu
RTL_TOP    := n64_ppu_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
